// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mem_request_unit_tb
FILELIST ?= mem_request_unit.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== common/mem_request_pkg.sv ====
// Word and tag widths, access size encoding, request and load result structs

package mem_request_pkg;

	// Data path and byte address width
	localparam int word_width = 32;

	// Tag carried by a request and echoed with its load result
	localparam int tag_width = 4;

	// Access size, the address must be aligned to it
	typedef enum logic [1:0]
	{
		size_byte = 2'd0,
		size_half = 2'd1,
		size_word = 2'd2
	} access_size_t;

	// One core request as held in the request queue
	typedef struct packed
	{
		logic is_store;
		access_size_t size;
		// Loads only, sign extends a byte or halfword
		logic sign_extend;
		logic [word_width - 1:0] address;
		logic [word_width - 1:0] store_data;
		logic [tag_width - 1:0] tag;
	} mem_request_t;

	// Aligned load value with its tag, as held in the response queue
	typedef struct packed
	{
		logic [word_width - 1:0] data;
		logic [tag_width - 1:0] tag;
	} load_result_t;

endpackage

// ==== fifo/sram_1r1w.sv ====
// Single read port, single write port memory array with write to read forwarding

`timescale 1ns/1ps

module sram_1r1w
	#(parameter type entry_t = logic [31:0],
	parameter SIZE = 4)

	(input clk,
	input [$clog2(SIZE) - 1:0] rd_addr_i,
	output entry_t rd_data_o,
	input [$clog2(SIZE) - 1:0] wr_addr_i,
	input wr_enable_i,
	input entry_t wr_data_i);

	// Storage, one entry per location
	entry_t data[SIZE];

	// Write port
	always_ff @(posedge clk)
	begin
		if (wr_enable_i)
			data[wr_addr_i] <= wr_data_i;
	end

	// Registered read port
	// A same cycle write to the read location bypasses the array
	always_ff @(posedge clk)
	begin
		if (wr_enable_i && wr_addr_i == rd_addr_i)
			rd_data_o <= wr_data_i;
		else
			rd_data_o <= data[rd_addr_i];
	end

endmodule

// ==== fifo/sync_fifo.sv ====
// Synchronous FIFO with flush, full/empty and almost-full/almost-empty flags, typed payload

`timescale 1ns/1ps

module sync_fifo
	#(parameter type payload_t = logic [31:0],
	parameter NUM_ENTRIES = 4,
	parameter ALMOST_FULL_THRESHOLD = 1,
	parameter ALMOST_EMPTY_THRESHOLD = 1)

	(input clk,
	input reset,
	input flush_i,
	output logic full_o,
	output logic almost_full_o,
	input enqueue_i,
	input payload_t value_i,
	output logic empty_o,
	output logic almost_empty_o,
	input dequeue_i,
	output payload_t value_o);

	localparam ADDR_WIDTH = $clog2(NUM_ENTRIES);

	// Pointer and count constants, sized to the registers they meet
	localparam logic [ADDR_WIDTH - 1:0] LAST_INDEX = ADDR_WIDTH'(NUM_ENTRIES - 1);
	localparam logic [ADDR_WIDTH:0] FULL_COUNT = (ADDR_WIDTH + 1)'(NUM_ENTRIES);
	localparam logic [ADDR_WIDTH:0] AF_RISE_COUNT =
		(ADDR_WIDTH + 1)'(NUM_ENTRIES - ALMOST_FULL_THRESHOLD - 1);
	localparam logic [ADDR_WIDTH:0] AF_FALL_COUNT =
		(ADDR_WIDTH + 1)'(NUM_ENTRIES - ALMOST_FULL_THRESHOLD);
	localparam logic [ADDR_WIDTH:0] AE_FALL_COUNT = (ADDR_WIDTH + 1)'(ALMOST_EMPTY_THRESHOLD);
	localparam logic [ADDR_WIDTH:0] AE_RISE_COUNT =
		(ADDR_WIDTH + 1)'(ALMOST_EMPTY_THRESHOLD + 1);

	logic [ADDR_WIDTH - 1:0] head_ff;
	logic [ADDR_WIDTH - 1:0] head_nxt;
	logic [ADDR_WIDTH - 1:0] tail_ff;
	logic [ADDR_WIDTH - 1:0] tail_nxt;
	logic [ADDR_WIDTH:0] count_ff;
	logic [ADDR_WIDTH:0] count_nxt;
	logic almost_full_nxt;
	logic almost_empty_nxt;

	// Read at the next head so the output always shows the head entry
	sram_1r1w #(.entry_t(payload_t), .SIZE(NUM_ENTRIES)) fifo_data(
		.clk(clk),
		.rd_addr_i(head_nxt),
		.rd_data_o(value_o),
		.wr_addr_i(tail_ff),
		.wr_enable_i(enqueue_i),
		.wr_data_i(value_i));

	always_comb
	begin
		if (flush_i)
		begin
			// Drop everything, back to the empty state
			head_nxt = '0;
			tail_nxt = '0;
			count_nxt = '0;
			almost_full_nxt = 1'b0;
			almost_empty_nxt = 1'b1;
		end
		else
		begin
			head_nxt = head_ff;
			tail_nxt = tail_ff;
			count_nxt = count_ff;
			almost_full_nxt = almost_full_o;
			almost_empty_nxt = almost_empty_o;

			// Pointers wrap at the last entry
			if (enqueue_i)
			begin
				if (tail_ff == LAST_INDEX)
					tail_nxt = '0;
				else
					tail_nxt = tail_ff + 1'b1;
			end

			if (dequeue_i)
			begin
				if (head_ff == LAST_INDEX)
					head_nxt = '0;
				else
					head_nxt = head_ff + 1'b1;
			end

			// Almost flags only change when the count crosses a threshold
			if (enqueue_i && !dequeue_i)
			begin
				count_nxt = count_ff + 1'b1;
				if (count_ff == AF_RISE_COUNT)
					almost_full_nxt = 1'b1;

				if (count_ff == AE_FALL_COUNT)
					almost_empty_nxt = 1'b0;
			end
			else if (dequeue_i && !enqueue_i)
			begin
				count_nxt = count_ff - 1'b1;
				if (count_ff == AF_FALL_COUNT)
					almost_full_nxt = 1'b0;

				if (count_ff == AE_RISE_COUNT)
					almost_empty_nxt = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			head_ff <= '0;
			tail_ff <= '0;
			count_ff <= '0;
			full_o <= 1'b0;
			almost_full_o <= 1'b0;
			empty_o <= 1'b1;
			almost_empty_o <= 1'b1;
		end
		else
		begin
			head_ff <= head_nxt;
			tail_ff <= tail_nxt;
			count_ff <= count_nxt;
			// Flags registered from the next count
			full_o <= count_nxt == FULL_COUNT;
			almost_full_o <= almost_full_nxt;
			empty_o <= count_nxt == '0;
			almost_empty_o <= almost_empty_nxt;
		end
	end

endmodule

// ==== mem_request_unit.f ====
common/mem_request_pkg.sv
fifo/sram_1r1w.sv
fifo/sync_fifo.sv
source/request_sequencer.sv
source/store_align.sv
source/load_align.sv
source/mem_request_unit.sv
tests/clock_gen.sv
tests/mem_model.sv
tests/mem_request_unit_tb.sv

// ==== source/load_align.sv ====
// Load aligner, selects the addressed byte or halfword lane and extends it

`timescale 1ns/1ps

module load_align
	(input [mem_request_pkg::word_width - 1:0] read_data_i,
	input mem_request_pkg::access_size_t size_i,
	input sign_extend_i,
	input [1:0] offset_i,
	output logic [mem_request_pkg::word_width - 1:0] data_o);

	logic [7:0] byte_lane;
	logic [15:0] half_lane;

	// Little-endian lanes, byte 0 in the low bits
	always_comb
	begin
		case (offset_i)
			2'd0: byte_lane = read_data_i[7:0];
			2'd1: byte_lane = read_data_i[15:8];
			2'd2: byte_lane = read_data_i[23:16];
			default: byte_lane = read_data_i[31:24];
		endcase
	end

	// Halfword alignment only looks at address bit 1
	assign half_lane = offset_i[1] ? read_data_i[31:16] : read_data_i[15:0];

	always_comb
	begin
		case (size_i)
			mem_request_pkg::size_byte:
			begin
				if (sign_extend_i)
					data_o = {{24{byte_lane[7]}}, byte_lane};
				else
					data_o = {24'd0, byte_lane};
			end

			mem_request_pkg::size_half:
			begin
				if (sign_extend_i)
					data_o = {{16{half_lane[15]}}, half_lane};
				else
					data_o = {16'd0, half_lane};
			end

			default:
				data_o = read_data_i;
		endcase
	end

endmodule

// ==== source/mem_request_unit.sv ====
// Memory request unit top, request and response queues, sequencer and aligners

`timescale 1ns/1ps

module mem_request_unit
	#(parameter REQ_DEPTH = 8,
	parameter RESP_DEPTH = 4,
	parameter REQ_ALMOST_FULL_THRESHOLD = 2,
	parameter ALMOST_EMPTY_THRESHOLD = 1)

	(input clk,
	input reset,
	input flush_i,
	input req_enqueue_i,
	input req_is_store_i,
	input mem_request_pkg::access_size_t req_size_i,
	input req_sign_extend_i,
	input [mem_request_pkg::word_width - 1:0] req_address_i,
	input [mem_request_pkg::word_width - 1:0] req_store_data_i,
	input [mem_request_pkg::tag_width - 1:0] req_tag_i,
	output logic req_almost_full_o,
	input resp_dequeue_i,
	output logic resp_empty_o,
	output logic [mem_request_pkg::word_width - 1:0] resp_data_o,
	output logic [mem_request_pkg::tag_width - 1:0] resp_tag_o,
	output logic mem_read_o,
	output logic mem_write_o,
	output logic [mem_request_pkg::word_width - 1:0] mem_address_o,
	output logic [mem_request_pkg::word_width - 1:0] mem_write_data_o,
	output logic [3:0] mem_byte_enable_o,
	input mem_ack_i,
	input [mem_request_pkg::word_width - 1:0] mem_read_data_i);

	mem_request_pkg::mem_request_t req_in;
	mem_request_pkg::mem_request_t req_head;
	mem_request_pkg::load_result_t resp_in;
	mem_request_pkg::load_result_t resp_head;
	mem_request_pkg::access_size_t pend_size;
	logic req_empty;
	logic req_dequeue;
	logic resp_full;
	logic resp_enqueue;
	logic pend_sign_extend;
	logic [1:0] pend_offset;
	logic [mem_request_pkg::tag_width - 1:0] pend_tag;
	logic [mem_request_pkg::word_width - 1:0] load_data;

	// Core request fields into one queue entry
	assign req_in = '{is_store: req_is_store_i, size: req_size_i,
		sign_extend: req_sign_extend_i, address: req_address_i,
		store_data: req_store_data_i, tag: req_tag_i};

	sync_fifo #(.payload_t(mem_request_pkg::mem_request_t), .NUM_ENTRIES(REQ_DEPTH),
		.ALMOST_FULL_THRESHOLD(REQ_ALMOST_FULL_THRESHOLD),
		.ALMOST_EMPTY_THRESHOLD(ALMOST_EMPTY_THRESHOLD)) request_fifo(
		.clk(clk), .reset(reset), .flush_i(flush_i),
		.full_o(), .almost_full_o(req_almost_full_o),
		.enqueue_i(req_enqueue_i), .value_i(req_in),
		.empty_o(req_empty), .almost_empty_o(),
		.dequeue_i(req_dequeue), .value_o(req_head));

	request_sequencer sequencer(
		.clk(clk), .reset(reset), .flush_i(flush_i),
		.req_empty_i(req_empty), .req_dequeue_o(req_dequeue), .req_head_i(req_head),
		.resp_full_i(resp_full), .resp_enqueue_o(resp_enqueue),
		.mem_read_o(mem_read_o), .mem_write_o(mem_write_o), .mem_ack_i(mem_ack_i),
		.pend_size_o(pend_size), .pend_sign_extend_o(pend_sign_extend),
		.pend_offset_o(pend_offset), .pend_tag_o(pend_tag));

	// Address and store lanes come straight from the queue head
	store_align store_aligner(
		.request_i(req_head), .word_address_o(mem_address_o),
		.write_data_o(mem_write_data_o), .byte_enable_o(mem_byte_enable_o));

	load_align load_aligner(
		.read_data_i(mem_read_data_i), .size_i(pend_size),
		.sign_extend_i(pend_sign_extend), .offset_i(pend_offset), .data_o(load_data));

	assign resp_in = '{data: load_data, tag: pend_tag};

	sync_fifo #(.payload_t(mem_request_pkg::load_result_t), .NUM_ENTRIES(RESP_DEPTH),
		.ALMOST_FULL_THRESHOLD(1), .ALMOST_EMPTY_THRESHOLD(ALMOST_EMPTY_THRESHOLD))
		response_fifo(
		.clk(clk), .reset(reset), .flush_i(flush_i),
		.full_o(resp_full), .almost_full_o(),
		.enqueue_i(resp_enqueue), .value_i(resp_in),
		.empty_o(resp_empty_o), .almost_empty_o(),
		.dequeue_i(resp_dequeue_i), .value_o(resp_head));

	assign resp_data_o = resp_head.data;
	assign resp_tag_o = resp_head.tag;

endmodule

// ==== source/request_sequencer.sv ====
// Request sequencer FSM, issues queued requests to memory and routes acknowledges

`timescale 1ns/1ps

module request_sequencer
	(input clk,
	input reset,
	input flush_i,
	input req_empty_i,
	output logic req_dequeue_o,
	input mem_request_pkg::mem_request_t req_head_i,
	input resp_full_i,
	output logic resp_enqueue_o,
	output logic mem_read_o,
	output logic mem_write_o,
	input mem_ack_i,
	output mem_request_pkg::access_size_t pend_size_o,
	output logic pend_sign_extend_o,
	output logic [1:0] pend_offset_o,
	output logic [mem_request_pkg::tag_width - 1:0] pend_tag_o);

	// Idle, access in flight, access in flight whose result is discarded
	typedef enum logic [1:0]
	{
		state_idle = 2'd0,
		state_wait = 2'd1,
		state_wait_cancel = 2'd2
	} seq_state_t;

	seq_state_t state_ff;
	seq_state_t state_nxt;
	logic issue;
	logic pend_is_store;

	// Issue only with a request ready and room for its result
	// No issue in a flush cycle, the head is about to be discarded
	assign issue = state_ff == state_idle && !req_empty_i && !resp_full_i && !flush_i;

	// Issue pops the request and strobes memory in the same cycle
	assign req_dequeue_o = issue;
	assign mem_read_o = issue && !req_head_i.is_store;
	assign mem_write_o = issue && req_head_i.is_store;

	// Load result pushed on the acknowledge cycle
	// Stores and cancelled accesses produce nothing
	assign resp_enqueue_o = state_ff == state_wait && mem_ack_i && !pend_is_store && !flush_i;

	always_comb
	begin
		state_nxt = state_ff;
		case (state_ff)
			state_idle:
			begin
				if (issue)
					state_nxt = state_wait;
			end

			state_wait:
			begin
				// Acknowledge wins over a flush in the same cycle
				if (mem_ack_i)
					state_nxt = state_idle;
				else if (flush_i)
					state_nxt = state_wait_cancel;
			end

			state_wait_cancel:
			begin
				// Swallow the late acknowledge
				if (mem_ack_i)
					state_nxt = state_idle;
			end

			default:
				state_nxt = state_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state_ff <= state_idle;
		else
			state_ff <= state_nxt;
	end

	// Fields of the issued access needed when its data returns
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			pend_is_store <= req_head_i.is_store;
			pend_size_o <= req_head_i.size;
			pend_sign_extend_o <= req_head_i.sign_extend;
			pend_offset_o <= req_head_i.address[1:0];
			pend_tag_o <= req_head_i.tag;
		end
	end

endmodule

// ==== source/store_align.sv ====
// Store aligner, word address, lane replicated write data and byte enables

`timescale 1ns/1ps

module store_align
	(input mem_request_pkg::mem_request_t request_i,
	output logic [mem_request_pkg::word_width - 1:0] word_address_o,
	output logic [mem_request_pkg::word_width - 1:0] write_data_o,
	output logic [3:0] byte_enable_o);

	// Memory is word addressed
	assign word_address_o = {2'b00, request_i.address[mem_request_pkg::word_width - 1:2]};

	always_comb
	begin
		case (request_i.size)
			mem_request_pkg::size_byte:
			begin
				// Same byte in every lane, enable picks the addressed one
				write_data_o = {4{request_i.store_data[7:0]}};
				byte_enable_o = 4'b0001 << request_i.address[1:0];
			end

			mem_request_pkg::size_half:
			begin
				// Halfword in both halves
				write_data_o = {2{request_i.store_data[15:0]}};
				byte_enable_o = request_i.address[1] ? 4'b1100 : 4'b0011;
			end

			default:
			begin
				write_data_o = request_i.store_data;
				byte_enable_o = 4'b1111;
			end
		endcase
	end

endmodule

// ==== tests/clock_gen.sv ====
// Testbench clock and power-on reset generator

`timescale 1ns/1ps

module clock_gen
	#(parameter PERIOD = 100,
	parameter RESET_CYCLES = 8)

	(output logic clk,
	output logic reset);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Reset released on a falling edge, away from the sampling edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== tests/mem_model.sv ====
// Testbench word memory with byte enables and random acknowledge latency

`timescale 1ns/1ps

module mem_model
	(input clk,
	input mem_read_i,
	input mem_write_i,
	input [31:0] address_i,
	input [31:0] write_data_i,
	input [3:0] byte_enable_i,
	output logic ack_o,
	output logic [31:0] read_data_o);

	logic [31:0] mem[64];
	logic [31:0] lfsr;
	logic [5:0] pending_index;
	int wait_count;

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return (state >> 1) ^ (state[0] ? 32'h80200003 : 32'h0);
	endfunction

	// Latency of 1 to 7 cycles from three LFSR bits
	function automatic int draw_latency();
		logic [2:0] bits;
		for (int i = 0; i < 3; i++)
		begin
			bits[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		return (int'(bits) % 7) + 1;
	endfunction

	initial
	begin
		lfsr = 32'he53108f2;
		wait_count = 0;
		pending_index = '0;
		ack_o = 1'b0;
		read_data_o = '0;
		// Known contents, every word differs
		for (int i = 0; i < 64; i++)
			mem[i] = (i + 1) * 32'h9e3779b1;
	end

	// Accept a strobe and apply store bytes at once
	always @(posedge clk)
	begin
		if (mem_read_i || mem_write_i)
		begin
			pending_index = address_i[5:0];
			wait_count = draw_latency();
			if (mem_write_i)
			begin
				for (int k = 0; k < 4; k++)
				begin
					if (byte_enable_i[k])
						mem[address_i[5:0]][8 * k +: 8] = write_data_i[8 * k +: 8];
				end
			end
		end
	end

	// Acknowledge and read data change on the falling edge
	always @(negedge clk)
	begin
		ack_o = 1'b0;
		if (wait_count != 0)
		begin
			wait_count = wait_count - 1;
			if (wait_count == 0)
			begin
				ack_o = 1'b1;
				read_data_o = mem[pending_index];
			end
		end
	end

endmodule

// ==== tests/mem_request_unit_tb.sv ====
// Testbench for the memory request unit with byte mirror, result queue and checks

`timescale 1ns/1ps

module mem_request_unit_tb;

	// Six tests of up to 20 requests at up to 10 cycles each, two and a half times over
	localparam int MAX_CYCLES = 6 * 20 * 10 * 5 / 2;

	typedef struct packed
	{
		logic is_store;
		logic [1:0] size;
		logic [31:0] address;
		logic [31:0] data;
	} request_record_t;

	logic clk;
	logic reset;
	logic flush_i;
	logic req_enqueue_i;
	logic req_is_store_i;
	mem_request_pkg::access_size_t req_size_i;
	logic req_sign_extend_i;
	logic [31:0] req_address_i;
	logic [31:0] req_store_data_i;
	logic [3:0] req_tag_i;
	logic req_almost_full_o;
	logic resp_dequeue_i;
	logic resp_empty_o;
	logic [31:0] resp_data_o;
	logic [3:0] resp_tag_o;
	logic mem_read_o;
	logic mem_write_o;
	logic [31:0] mem_address_o;
	logic [31:0] mem_write_data_o;
	logic [3:0] mem_byte_enable_o;
	logic mem_ack_i;
	logic [31:0] mem_read_data_i;

	// Byte mirror of memory and expected {data, tag} results
	logic [7:0] mirror[256];
	logic [35:0] expected_q[$];
	request_record_t issued_q[$];
	int queued_requests = 0;
	int result_count = 0;
	logic in_flight = 1'b0;
	logic in_flight_store = 1'b0;
	logic cancelled = 1'b0;
	int checks = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_passed = 0;
	int cycles = 0;
	int errors_before;

	clock_gen #(.PERIOD(100), .RESET_CYCLES(8)) clocks(.clk(clk), .reset(reset));

	mem_model memory(
		.clk(clk), .mem_read_i(mem_read_o), .mem_write_i(mem_write_o),
		.address_i(mem_address_o), .write_data_i(mem_write_data_o),
		.byte_enable_i(mem_byte_enable_o), .ack_o(mem_ack_i),
		.read_data_o(mem_read_data_i));

	mem_request_unit #(.REQ_DEPTH(8), .RESP_DEPTH(4), .REQ_ALMOST_FULL_THRESHOLD(2),
		.ALMOST_EMPTY_THRESHOLD(1)) UUT(
		.clk(clk), .reset(reset), .flush_i(flush_i),
		.req_enqueue_i(req_enqueue_i), .req_is_store_i(req_is_store_i),
		.req_size_i(req_size_i), .req_sign_extend_i(req_sign_extend_i),
		.req_address_i(req_address_i), .req_store_data_i(req_store_data_i),
		.req_tag_i(req_tag_i), .req_almost_full_o(req_almost_full_o),
		.resp_dequeue_i(resp_dequeue_i), .resp_empty_o(resp_empty_o),
		.resp_data_o(resp_data_o), .resp_tag_o(resp_tag_o),
		.mem_read_o(mem_read_o), .mem_write_o(mem_write_o),
		.mem_address_o(mem_address_o), .mem_write_data_o(mem_write_data_o),
		.mem_byte_enable_o(mem_byte_enable_o), .mem_ack_i(mem_ack_i),
		.mem_read_data_i(mem_read_data_i));

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got === expected)
		else
		begin
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic confirm(input logic condition, input string what);
		checks++;
		assert (condition)
		else
		begin
			$display("At %0t: %s", $time, what);
			errors++;
		end
	endtask

	// Little-endian lane from the mirror with the requested extension
	function automatic logic [31:0] expected_load(input logic [31:0] address,
		input logic [1:0] size, input logic sign_extend);
		logic [7:0] b;
		logic [15:0] h;
		b = mirror[address[7:0]];
		h = {mirror[address[7:0] + 8'd1], b};
		if (size == mem_request_pkg::size_byte)
			return sign_extend ? {{24{b[7]}}, b} : {24'd0, b};
		else if (size == mem_request_pkg::size_half)
			return sign_extend ? {{16{h[15]}}, h} : {16'd0, h};
		return {mirror[address[7:0] + 8'd3], mirror[address[7:0] + 8'd2], h};
	endfunction

	function automatic int size_bytes(input logic [1:0] size);
		if (size == mem_request_pkg::size_byte)
			return 1;
		else if (size == mem_request_pkg::size_half)
			return 2;
		return 4;
	endfunction

	// Lane k of the bus carries data byte k modulo the access size
	task automatic inspect_issue(input request_record_t rec);
		int offset;
		int count;
		logic [3:0] enables;
		offset = int'(rec.address[1:0]);
		count = size_bytes(rec.size);
		compare_value("mem_address_o", mem_address_o, rec.address >> 2);
		compare_value("mem_read_o", 32'(mem_read_o), 32'(!rec.is_store));
		compare_value("mem_write_o", 32'(mem_write_o), 32'(rec.is_store));
		if (rec.is_store)
		begin
			for (int k = 0; k < 4; k++)
				enables[k] = k >= offset && k < offset + count;
			compare_value("mem_byte_enable_o", 32'(mem_byte_enable_o), 32'(enables));
			// Disabled lanes still carry the replicated data
			for (int k = 0; k < 4; k++)
				compare_value("mem_write_data_o lane", 32'(mem_write_data_o[8 * k +: 8]),
					32'(rec.data[8 * (k % count) +: 8]));
		end
	endtask

	// Observes the DUT at the rising edge and tracks queue occupancy
	always @(posedge clk)
	begin
		if (!reset)
		begin
			compare_value("req_almost_full_o", 32'(req_almost_full_o),
				32'(queued_requests >= 6));
			if (mem_ack_i)
			begin
				if (!in_flight_store && !cancelled && !flush_i)
					result_count++;
				in_flight = 1'b0;
				cancelled = 1'b0;
			end
			if (mem_read_o || mem_write_o)
			begin
				// Only one access may be outstanding
				confirm(!in_flight, "memory strobe while an access is in flight");
				confirm(result_count < 4, "memory strobe while four results are queued");
				if (issued_q.size() == 0)
					confirm(1'b0, "memory strobe with no queued request");
				else
					inspect_issue(issued_q.pop_front());
				in_flight = 1'b1;
				in_flight_store = mem_write_o;
				queued_requests--;
			end
			if (req_enqueue_i)
				queued_requests++;
			if (resp_dequeue_i)
				result_count--;
			if (flush_i)
			begin
				queued_requests = 0;
				result_count = 0;
				issued_q.delete();
				if (in_flight)
					cancelled = 1'b1;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// Starts on a falling edge and returns on the next one
	task automatic enqueue_request(input logic is_store,
		input mem_request_pkg::access_size_t size, input logic sign_extend,
		input logic [31:0] address, input logic [31:0] data, input logic [3:0] tag);
		request_record_t rec;
		while (req_almost_full_o)
			@(negedge clk);
		req_enqueue_i = 1'b1;
		req_is_store_i = is_store;
		req_size_i = size;
		req_sign_extend_i = sign_extend;
		req_address_i = address;
		req_store_data_i = data;
		req_tag_i = tag;
		rec = '{is_store: is_store, size: size, address: address, data: data};
		issued_q.push_back(rec);
		if (is_store)
		begin
			for (int k = 0; k < size_bytes(size); k++)
				mirror[address[7:0] + 8'(k)] = data[8 * k +: 8];
		end
		else
			expected_q.push_back({expected_load(address, size, sign_extend), tag});
		@(negedge clk);
		req_enqueue_i = 1'b0;
	endtask

	// Pops every expected result and compares it with the queue head
	task automatic drain_results;
		logic [35:0] expected;
		while (expected_q.size() != 0)
		begin
			if (!resp_empty_o)
			begin
				expected = expected_q.pop_front();
				compare_value("resp_data_o", resp_data_o, expected[35:4]);
				compare_value("resp_tag_o", 32'(resp_tag_o), 32'(expected[3:0]));
				resp_dequeue_i = 1'b1;
			end
			else
				resp_dequeue_i = 1'b0;
			@(negedge clk);
		end
		resp_dequeue_i = 1'b0;
		while (in_flight)
			@(negedge clk);
	endtask

	task automatic finish_test(input int number, input string name);
		tests_run++;
		if (errors == errors_before)
		begin
			tests_passed++;
			$display("Test %0d %s: passed", number, name);
		end
		else
			$display("Test %0d %s: %0d errors", number, name, errors - errors_before);
		errors_before = errors;
	endtask

	initial
	begin
		flush_i = 1'b0;
		req_enqueue_i = 1'b0;
		req_is_store_i = 1'b0;
		req_size_i = mem_request_pkg::size_word;
		req_sign_extend_i = 1'b0;
		req_address_i = '0;
		req_store_data_i = '0;
		req_tag_i = '0;
		resp_dequeue_i = 1'b0;
		errors_before = 0;
		for (int i = 0; i < 64; i++)
		begin
			for (int k = 0; k < 4; k++)
				mirror[4 * i + k] = 8'(((i + 1) * 32'h9e3779b1) >> (8 * k));
		end

		@(negedge clk);
		while (reset)
			@(negedge clk);

		// Idle outputs after reset
		compare_value("mem_read_o", 32'(mem_read_o), 32'd0);
		compare_value("mem_write_o", 32'(mem_write_o), 32'd0);
		compare_value("req_almost_full_o", 32'(req_almost_full_o), 32'd0);
		compare_value("resp_empty_o", 32'(resp_empty_o), 32'd1);
		finish_test(1, "reset state");

		for (int i = 0; i < 6; i++)
			enqueue_request(1'b1, mem_request_pkg::size_word, 1'b0, 32'(20 * i + 8),
				32'hc0de0000 + 32'(i * 32'h1111), 4'(i));
		for (int i = 0; i < 6; i++)
			enqueue_request(1'b0, mem_request_pkg::size_word, 1'b0, 32'(20 * i + 8),
				32'h0, 4'(i + 6));
		drain_results();
		finish_test(2, "word store and load");

		// Every byte and halfword offset with both extensions
		for (int off = 0; off < 4; off++)
		begin
			for (int s = 0; s < 2; s++)
				enqueue_request(1'b0, mem_request_pkg::size_byte, 1'(s), 32'(80 + 4 * off + off),
					32'h0, 4'(2 * off + s));
		end
		// Results drained before the halfword loads to keep the request queue moving
		drain_results();
		for (int off = 0; off < 4; off += 2)
		begin
			for (int s = 0; s < 2; s++)
				enqueue_request(1'b0, mem_request_pkg::size_half, 1'(s), 32'(100 + off),
					32'h0, 4'(off + s + 8));
		end
		drain_results();
		finish_test(3, "byte and halfword loads");

		enqueue_request(1'b1, mem_request_pkg::size_byte, 1'b0, 32'd192, 32'hdeadbe5a, 4'd0);
		enqueue_request(1'b1, mem_request_pkg::size_byte, 1'b0, 32'd195, 32'h123456a7, 4'd0);
		enqueue_request(1'b1, mem_request_pkg::size_byte, 1'b0, 32'd201, 32'hffffff3c, 4'd0);
		enqueue_request(1'b1, mem_request_pkg::size_half, 1'b0, 32'd206, 32'h9876f00d, 4'd0);
		enqueue_request(1'b1, mem_request_pkg::size_half, 1'b0, 32'd212, 32'h0000beef, 4'd0);
		enqueue_request(1'b0, mem_request_pkg::size_word, 1'b0, 32'd192, 32'h0, 4'd1);
		enqueue_request(1'b0, mem_request_pkg::size_word, 1'b0, 32'd200, 32'h0, 4'd2);
		enqueue_request(1'b0, mem_request_pkg::size_word, 1'b0, 32'd204, 32'h0, 4'd3);
		enqueue_request(1'b0, mem_request_pkg::size_word, 1'b0, 32'd212, 32'h0, 4'd4);
		drain_results();
		finish_test(4, "byte and halfword stores");

		// Results pile up with no dequeue until both queues stall
		for (int i = 0; i < 10; i++)
			enqueue_request(1'b0, mem_request_pkg::size_word, 1'b0, 32'(4 * i), 32'h0, 4'(i));
		while (!(result_count == 4 && queued_requests == 6))
			@(negedge clk);
		repeat (10)
			@(negedge clk);
		drain_results();
		finish_test(5, "queue limits");

		enqueue_request(1'b0, mem_request_pkg::size_word, 1'b0, 32'd40, 32'h0, 4'd1);
		while (result_count != 1)
			@(negedge clk);
		for (int i = 0; i < 4; i++)
			enqueue_request(1'b0, mem_request_pkg::size_byte, 1'b1, 32'(60 + i), 32'h0, 4'(i));
		while (!in_flight)
			@(negedge clk);
		flush_i = 1'b1;
		expected_q.delete();
		@(negedge clk);
		flush_i = 1'b0;
		compare_value("resp_empty_o", 32'(resp_empty_o), 32'd1);
		while (in_flight)
			@(negedge clk);
		repeat (3)
			@(negedge clk);
		compare_value("resp_empty_o", 32'(resp_empty_o), 32'd1);
		compare_value("result count", 32'(result_count), 32'd0);
		enqueue_request(1'b0, mem_request_pkg::size_half, 1'b1, 32'd130, 32'h0, 4'd9);
		drain_results();
		finish_test(6, "flush");

		$display("Tests passed %0d of %0d, checks %0d, errors %0d",
			tests_passed, tests_run, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
